// ==== design/bus_bridge.sv ====
// bus bridge
// registers one request from the memory controller onto the external
// generic bus, holds it until the bus is ready, then returns the result
// with mc_busy low for exactly one cycle

`timescale 1ns/100ps

module bus_bridge (
  input  logic              CLK,
  input  logic              nRST,
  // upstream from the memory controller
  input  logic              mc_ren,
  input  logic              mc_wen,
  input  mem_pkg::addr_t    mc_addr,
  input  mem_pkg::word_t    mc_wdata,
  input  mem_pkg::byte_en_t mc_byte_en,
  output mem_pkg::word_t    mc_rdata,
  output logic              mc_busy,
  // external generic bus
  output logic              ext_ren,
  output logic              ext_wen,
  output mem_pkg::addr_t    ext_addr,
  output mem_pkg::word_t    ext_wdata,
  output mem_pkg::byte_en_t ext_byte_en,
  input  mem_pkg::word_t    ext_rdata,
  input  logic              ext_busy
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_RESP
  } state_t;

  state_t state_q;

  // registered strobes
  logic ext_ren_q;
  logic ext_wen_q;

  // registered payload
  mem_pkg::addr_t    addr_q;
  mem_pkg::word_t    wdata_q;
  mem_pkg::byte_en_t byte_en_q;
  mem_pkg::word_t    rdata_q;

  assign ext_ren     = ext_ren_q;
  assign ext_wen     = ext_wen_q;
  assign ext_addr    = addr_q;
  assign ext_wdata   = wdata_q;
  assign ext_byte_en = byte_en_q;

  // one response cycle per access
  assign mc_busy  = (state_q != ST_RESP);
  assign mc_rdata = rdata_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q   <= ST_IDLE;
      ext_ren_q <= 1'b0;
      ext_wen_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // accept and drive the bus next cycle
          if (mc_ren || mc_wen) begin
            ext_ren_q <= mc_ren;
            ext_wen_q <= mc_wen;
            state_q   <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          // strobes drop once the bus takes the access
          if (!ext_busy) begin
            ext_ren_q <= 1'b0;
            ext_wen_q <= 1'b0;
            state_q   <= ST_RESP;
          end
        end
        default: begin
          // back to idle after the response cycle
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge CLK) begin
    if (state_q == ST_IDLE && (mc_ren || mc_wen)) begin
      addr_q    <= mc_addr;
      wdata_q   <= mc_wdata;
      byte_en_q <= mc_byte_en;
    end
    if (state_q == ST_ISSUE && !ext_busy) begin
      rdata_q <= ext_rdata;
    end
  end

endmodule

// ==== design/core_mem_top.sv ====
// core memory side top level
// instruction cache and uncached data port merged by the memory
// controller, then bridged onto the external generic bus

`timescale 1ns/100ps

module core_mem_top #(
  parameter int ICACHE_LINES = 16
) (
  input  logic              CLK,
  input  logic              nRST,
  // halt
  input  logic              halt_instr,
  output logic              halt,
  // fetch port
  input  logic              i_ren,
  input  mem_pkg::addr_t    i_addr,
  output mem_pkg::word_t    i_rdata,
  output logic              i_busy,
  // data port
  input  logic              d_ren,
  input  logic              d_wen,
  input  mem_pkg::addr_t    d_addr,
  input  mem_pkg::word_t    d_wdata,
  input  mem_pkg::byte_en_t d_byte_en,
  output mem_pkg::word_t    d_rdata,
  output logic              d_busy,
  // external generic bus
  output logic              ext_ren,
  output logic              ext_wen,
  output mem_pkg::addr_t    ext_addr,
  output mem_pkg::word_t    ext_wdata,
  output mem_pkg::byte_en_t ext_byte_en,
  input  mem_pkg::word_t    ext_rdata,
  input  logic              ext_busy
);

  // cache fill path
  logic              fill_ren;
  mem_pkg::addr_t    fill_addr;
  mem_pkg::word_t    fill_rdata;
  logic              fill_busy;

  // controller to bridge
  logic              mc_ren;
  logic              mc_wen;
  mem_pkg::addr_t    mc_addr;
  mem_pkg::word_t    mc_wdata;
  mem_pkg::byte_en_t mc_byte_en;
  mem_pkg::word_t    mc_rdata;
  logic              mc_busy;

  instr_cache #(
    .ICACHE_LINES(ICACHE_LINES)
  ) icache_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_ren     (i_ren),
    .i_addr    (i_addr),
    .i_rdata   (i_rdata),
    .i_busy    (i_busy),
    .fill_ren  (fill_ren),
    .fill_addr (fill_addr),
    .fill_rdata(fill_rdata),
    .fill_busy (fill_busy)
  );

  // fills on the instruction side, data port uncached
  memory_controller mc_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt_instr(halt_instr),
    .halt      (halt),
    .i_ren     (fill_ren),
    .i_addr    (fill_addr),
    .i_rdata   (fill_rdata),
    .i_busy    (fill_busy),
    .d_ren     (d_ren),
    .d_wen     (d_wen),
    .d_addr    (d_addr),
    .d_wdata   (d_wdata),
    .d_byte_en (d_byte_en),
    .d_rdata   (d_rdata),
    .d_busy    (d_busy),
    .mc_ren    (mc_ren),
    .mc_wen    (mc_wen),
    .mc_addr   (mc_addr),
    .mc_wdata  (mc_wdata),
    .mc_byte_en(mc_byte_en),
    .mc_rdata  (mc_rdata),
    .mc_busy   (mc_busy)
  );

  bus_bridge bridge_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .mc_ren     (mc_ren),
    .mc_wen     (mc_wen),
    .mc_addr    (mc_addr),
    .mc_wdata   (mc_wdata),
    .mc_byte_en (mc_byte_en),
    .mc_rdata   (mc_rdata),
    .mc_busy    (mc_busy),
    .ext_ren    (ext_ren),
    .ext_wen    (ext_wen),
    .ext_addr   (ext_addr),
    .ext_wdata  (ext_wdata),
    .ext_byte_en(ext_byte_en),
    .ext_rdata  (ext_rdata),
    .ext_busy   (ext_busy)
  );

endmodule

// ==== design/instr_cache.sv ====
// instruction cache
// direct-mapped, read-only, one word per line
// hits answer in the same cycle, misses fill one word through the
// memory controller and complete one cycle after the fill returns

`timescale 1ns/100ps

module instr_cache #(
  parameter int ICACHE_LINES = 16
) (
  input  logic           CLK,
  input  logic           nRST,
  // fetch side
  input  logic           i_ren,
  input  mem_pkg::addr_t i_addr,
  output mem_pkg::word_t i_rdata,
  output logic           i_busy,
  // fill side towards the memory controller
  output logic           fill_ren,
  output mem_pkg::addr_t fill_addr,
  input  mem_pkg::word_t fill_rdata,
  input  logic           fill_busy
);

  // index and tag split of the byte address
  localparam int IDX_W = $clog2(ICACHE_LINES);
  localparam int TAG_W = mem_pkg::ADDR_W - IDX_W - mem_pkg::BYTE_OFF_W;

  typedef enum logic [1:0] {
    ST_LOOKUP,
    ST_FILL,
    ST_DONE
  } state_t;

  state_t state_q;

  // line storage
  logic [ICACHE_LINES-1:0] valid_q;
  logic [TAG_W-1:0]        tag_mem [ICACHE_LINES];
  mem_pkg::word_t          data_mem [ICACHE_LINES];

  // address of the current lookup
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             hit;

  // miss bookkeeping
  mem_pkg::addr_t   miss_addr_q;
  logic [IDX_W-1:0] miss_idx;
  logic [TAG_W-1:0] miss_tag;
  mem_pkg::word_t   fill_word_q;

  assign idx = i_addr[mem_pkg::BYTE_OFF_W +: IDX_W];
  assign tag = i_addr[mem_pkg::ADDR_W-1 -: TAG_W];

  assign miss_idx = miss_addr_q[mem_pkg::BYTE_OFF_W +: IDX_W];
  assign miss_tag = miss_addr_q[mem_pkg::ADDR_W-1 -: TAG_W];

  // lookup only counts while idle in lookup state
  assign hit = (state_q == ST_LOOKUP) && i_ren && valid_q[idx] && (tag_mem[idx] == tag);

  // fill request held for the whole fill state
  assign fill_ren  = (state_q == ST_FILL);
  // word aligned fill address
  assign fill_addr = {miss_addr_q[mem_pkg::ADDR_W-1:mem_pkg::BYTE_OFF_W],
                      {mem_pkg::BYTE_OFF_W{1'b0}}};

  // fetch side response
  always_comb begin
    case (state_q)
      ST_LOOKUP: begin
        i_busy  = !hit;
        i_rdata = data_mem[idx];
      end
      ST_DONE: begin
        // registered fill word for one completion cycle
        i_busy  = 1'b0;
        i_rdata = fill_word_q;
      end
      default: begin
        i_busy  = 1'b1;
        i_rdata = data_mem[idx];
      end
    endcase
  end

  // control state and valid bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= ST_LOOKUP;
      valid_q <= '0;
    end else begin
      case (state_q)
        ST_LOOKUP: begin
          // miss starts the fill next cycle
          if (i_ren && !hit) begin
            state_q <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (!fill_busy) begin
            valid_q[miss_idx] <= 1'b1;
            state_q           <= ST_DONE;
          end
        end
        default: begin
          state_q <= ST_LOOKUP;
        end
      endcase
    end
  end

  // tags, words and miss payload
  always_ff @(posedge CLK) begin
    if (state_q == ST_LOOKUP && i_ren && !hit) begin
      miss_addr_q <= i_addr;
    end
    if (state_q == ST_FILL && !fill_busy) begin
      tag_mem[miss_idx]  <= miss_tag;
      data_mem[miss_idx] <= fill_rdata;
      fill_word_q        <= fill_rdata;
    end
  end

endmodule

// ==== design/mem_pkg.sv ====
// memory side shared definitions
// word, address and byte enable types plus bus width constants
// used by the instruction cache, memory controller and bus bridge

package mem_pkg;

  // data word width in bits
  parameter int WORD_W = 32;

  // byte address width in bits
  parameter int ADDR_W = 32;

  // bits per byte lane
  parameter int BYTE_W = 8;

  // byte lanes in one word
  parameter int BYTES_PER_WORD = WORD_W / BYTE_W;

  // byte offset bits inside a word, ignored on every port
  parameter int BYTE_OFF_W = $clog2(BYTES_PER_WORD);

  // one data or instruction word
  typedef logic [WORD_W-1:0] word_t;

  // byte address, word aligned in practice
  typedef logic [ADDR_W-1:0] addr_t;

  // bit n enables byte n of word_t
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

  // full word access, used for instruction fills
  parameter byte_en_t BYTE_EN_ALL = '1;

endpackage

// ==== design/memory_controller.sv ====
// memory controller
// merges the instruction fill and data requesters into one bus master
// data wins in an idle cycle, the grant locks until the access completes
// also holds the halt latch, which blocks any new grant once set

`timescale 1ns/100ps

module memory_controller (
  input  logic              CLK,
  input  logic              nRST,
  // halt from the commit side
  input  logic              halt_instr,
  output logic              halt,
  // instruction requester, fills only
  input  logic              i_ren,
  input  mem_pkg::addr_t    i_addr,
  output mem_pkg::word_t    i_rdata,
  output logic              i_busy,
  // data requester
  input  logic              d_ren,
  input  logic              d_wen,
  input  mem_pkg::addr_t    d_addr,
  input  mem_pkg::word_t    d_wdata,
  input  mem_pkg::byte_en_t d_byte_en,
  output mem_pkg::word_t    d_rdata,
  output logic              d_busy,
  // merged master towards the bus bridge
  output logic              mc_ren,
  output logic              mc_wen,
  output mem_pkg::addr_t    mc_addr,
  output mem_pkg::word_t    mc_wdata,
  output mem_pkg::byte_en_t mc_byte_en,
  input  mem_pkg::word_t    mc_rdata,
  input  logic              mc_busy
);

  typedef enum logic [1:0] {
    GNT_IDLE,
    GNT_INSTR,
    GNT_DATA
  } grant_t;

  // locked grant
  grant_t grant_q;
  // grant seen this cycle, same as grant_q unless idle
  grant_t sel;

  logic halt_latch_q;
  logic d_req;
  logic done;

  assign d_req = d_ren || d_wen;

  // idle grants in the same cycle, data first
  // nothing new once halt is latched
  always_comb begin
    sel = grant_q;
    if (grant_q == GNT_IDLE && !halt_latch_q) begin
      if (d_req) begin
        sel = GNT_DATA;
      end else if (i_ren) begin
        sel = GNT_INSTR;
      end
    end
  end

  // granted side onto the merged bus
  always_comb begin
    case (sel)
      GNT_DATA: begin
        mc_ren     = d_ren;
        mc_wen     = d_wen;
        mc_addr    = d_addr;
        mc_wdata   = d_wdata;
        mc_byte_en = d_byte_en;
      end
      GNT_INSTR: begin
        // fills are full word reads
        mc_ren     = i_ren;
        mc_wen     = 1'b0;
        mc_addr    = i_addr;
        mc_wdata   = '0;
        mc_byte_en = mem_pkg::BYTE_EN_ALL;
      end
      default: begin
        mc_ren     = 1'b0;
        mc_wen     = 1'b0;
        mc_addr    = d_addr;
        mc_wdata   = '0;
        mc_byte_en = '0;
      end
    endcase
  end

  // completion of the granted access
  assign done = (sel != GNT_IDLE) && !mc_busy;

  // busy low and read data only to the granted side
  assign d_busy  = !(done && sel == GNT_DATA);
  assign i_busy  = !(done && sel == GNT_INSTR);
  assign d_rdata = (sel == GNT_DATA)  ? mc_rdata : '0;
  assign i_rdata = (sel == GNT_INSTR) ? mc_rdata : '0;

  // halt once latched and nothing in flight
  assign halt = halt_latch_q && (grant_q == GNT_IDLE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grant_q      <= GNT_IDLE;
      halt_latch_q <= 1'b0;
    end else begin
      // release on completion, otherwise lock what was seen
      if (done) begin
        grant_q <= GNT_IDLE;
      end else begin
        grant_q <= sel;
      end
      // sticky until reset
      if (halt_instr) begin
        halt_latch_q <= 1'b1;
      end
    end
  end

endmodule

// ==== flist.f ====
design/mem_pkg.sv
design/instr_cache.sv
design/memory_controller.sv
design/bus_bridge.sv
design/core_mem_top.sv
tb/ext_mem_model.sv
tb/tb_core_mem.sv

// ==== tb/ext_mem_model.sv ====
// external memory model
// word array preloaded from an address pattern, answers each access
// on the generic bus after 0 to 3 random extra cycles

`timescale 1ns/100ps

module ext_mem_model #(
  parameter int DEPTH = 1024
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              ext_ren,
  input  logic              ext_wen,
  input  mem_pkg::addr_t    ext_addr,
  input  mem_pkg::word_t    ext_wdata,
  input  mem_pkg::byte_en_t ext_byte_en,
  output mem_pkg::word_t    ext_rdata,
  output logic              ext_busy
);

  localparam int IDX_W = $clog2(DEPTH);

  mem_pkg::word_t   mem [DEPTH];
  // wait cycles spent and wanted for the current access
  logic [1:0]       wait_q;
  logic [1:0]       lat_q;
  logic [IDX_W-1:0] idx;
  logic             req;
  integer           seed;

  assign req       = ext_ren || ext_wen;
  assign idx       = ext_addr[mem_pkg::BYTE_OFF_W +: IDX_W];
  assign ext_busy  = !(req && wait_q == lat_q);
  assign ext_rdata = mem[idx];

  initial begin
    seed = 32'h0b8e89a6;
    // pattern of the full byte address of each word
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (i * 4 * 32'h9e3779b9) ^ 32'h5ac396e1;
    end
  end

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wait_q <= '0;
      lat_q  <= '0;
    end else if (req && !ext_busy) begin
      // write merged by byte enable
      if (ext_wen) begin
        for (int b = 0; b < mem_pkg::BYTES_PER_WORD; b++) begin
          if (ext_byte_en[b]) begin
            mem[idx][mem_pkg::BYTE_W*b +: mem_pkg::BYTE_W] <=
              ext_wdata[mem_pkg::BYTE_W*b +: mem_pkg::BYTE_W];
          end
        end
      end
      // latency for the next access
      wait_q <= '0;
      lat_q  <= $random(seed);
    end else if (req) begin
      wait_q <= wait_q + 1'b1;
    end
  end

endmodule

// ==== tb/tb_core_mem.sv ====
// testbench for the core memory side
// directed tests drive the fetch and data ports and pulse halt,
// an external memory model answers on the generic bus

`timescale 1ns/100ps

module tb_core_mem;

  localparam int ICACHE_LINES = 16;
  localparam int MEM_WORDS    = 1024;
  localparam int IDX_W        = $clog2(MEM_WORDS);
  // six tests of up to about 500 cycles, doubled
  localparam int MAX_CYCLES   = 6000;
  localparam int WAIT_LIMIT   = 50;

  logic              CLK = 1'b0;
  logic              nRST;
  logic              halt_instr;
  logic              halt;
  logic              i_ren;
  mem_pkg::addr_t    i_addr;
  mem_pkg::word_t    i_rdata;
  logic              i_busy;
  logic              d_ren;
  logic              d_wen;
  mem_pkg::addr_t    d_addr;
  mem_pkg::word_t    d_wdata;
  mem_pkg::byte_en_t d_byte_en;
  mem_pkg::word_t    d_rdata;
  logic              d_busy;
  logic              ext_ren;
  logic              ext_wen;
  mem_pkg::addr_t    ext_addr;
  mem_pkg::word_t    ext_wdata;
  mem_pkg::byte_en_t ext_byte_en;
  mem_pkg::word_t    ext_rdata;
  logic              ext_busy;

  // expected memory, preload pattern with data writes merged in
  mem_pkg::word_t shadow [MEM_WORDS];
  // addresses of completed external accesses, oldest first
  mem_pkg::addr_t ext_log [$];
  // payload of completed external writes, oldest first
  mem_pkg::word_t    wr_data_log [$];
  mem_pkg::byte_en_t wr_be_log [$];
  int             cycle_cnt = 0;
  integer         seed = 32'h0b8e89a6;

  core_mem_top #(.ICACHE_LINES(ICACHE_LINES)) dut_i (.*);
  ext_mem_model #(.DEPTH(MEM_WORDS)) mem_i (.*);

  always #2 CLK = ~CLK;

  function automatic mem_pkg::word_t pattern(input mem_pkg::addr_t a);
    return (a * 32'h9e3779b9) ^ 32'h5ac396e1;
  endfunction

  function automatic mem_pkg::word_t merge_bytes(input mem_pkg::word_t old,
                                                 input mem_pkg::word_t wd,
                                                 input mem_pkg::byte_en_t be);
    mem_pkg::word_t res;
    res = old;
    for (int b = 0; b < mem_pkg::BYTES_PER_WORD; b++) begin
      if (be[b]) begin
        res[mem_pkg::BYTE_W*b +: mem_pkg::BYTE_W] = wd[mem_pkg::BYTE_W*b +: mem_pkg::BYTE_W];
      end
    end
    return res;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input mem_pkg::addr_t exp,
                            input mem_pkg::addr_t act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_byte_en(input string name, input mem_pkg::byte_en_t exp,
                               input mem_pkg::byte_en_t act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act));
    end
  endtask

  // completed accesses seen on the external bus
  always @(negedge CLK) begin
    if ((ext_ren || ext_wen) && !ext_busy) begin
      ext_log.push_back(ext_addr);
    end
    if (ext_wen && !ext_busy) begin
      wr_data_log.push_back(ext_wdata);
      wr_be_log.push_back(ext_byte_en);
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // one data access, held until d_busy drops
  task automatic data_access(input logic wr, input mem_pkg::addr_t a, input mem_pkg::word_t wd,
                             input mem_pkg::byte_en_t be, output mem_pkg::word_t rd);
    int n;
    n = 0;
    @(posedge CLK);
    d_ren     <= !wr;
    d_wen     <= wr;
    d_addr    <= a;
    d_wdata   <= wd;
    d_byte_en <= be;
    do begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) begin
        stop_run($sformatf("data access to 0x%h got no response in %0d cycles", a, n));
      end
    end while (d_busy);
    rd = d_rdata;
    @(posedge CLK);
    d_ren <= 1'b0;
    d_wen <= 1'b0;
  endtask

  // write payload must reach the external bus unchanged
  task automatic data_write(input mem_pkg::addr_t a, input mem_pkg::word_t wd,
                            input mem_pkg::byte_en_t be);
    mem_pkg::word_t unused;
    ext_log.delete();
    wr_data_log.delete();
    wr_be_log.delete();
    data_access(1'b1, a, wd, be, unused);
    check_bit("single ext access on a write", 1'b1, ext_log.size() == 1);
    check_bit("single ext_wen on a write", 1'b1, wr_data_log.size() == 1);
    check_addr("ext_addr", a, ext_log[0]);
    check_word("ext_wdata", wd, wr_data_log[0]);
    check_byte_en("ext_byte_en", be, wr_be_log[0]);
    shadow[a[2 +: IDX_W]] = merge_bytes(shadow[a[2 +: IDX_W]], wd, be);
  endtask

  task automatic data_read_check(input mem_pkg::addr_t a);
    mem_pkg::word_t rd;
    wr_data_log.delete();
    data_access(1'b0, a, '0, mem_pkg::BYTE_EN_ALL, rd);
    check_bit("ext_wen on a read", 1'b0, wr_data_log.size() != 0);
    check_word("d_rdata", shadow[a[2 +: IDX_W]], rd);
  endtask

  // hit means i_busy was already low in the request cycle
  task automatic fetch(input mem_pkg::addr_t a, output mem_pkg::word_t rd, output logic hit);
    int n;
    n = 0;
    @(posedge CLK);
    i_ren  <= 1'b1;
    i_addr <= a;
    do begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) begin
        stop_run($sformatf("fetch from 0x%h got no response in %0d cycles", a, n));
      end
    end while (i_busy);
    rd  = i_rdata;
    hit = (n == 1);
    @(posedge CLK);
    i_ren <= 1'b0;
  endtask

  task automatic fetch_check(input mem_pkg::addr_t a, input logic exp_hit);
    mem_pkg::word_t rd;
    logic           hit;
    ext_log.delete();
    fetch(a, rd, hit);
    check_word("i_rdata", pattern(a), rd);
    check_bit("i_busy low in request cycle", exp_hit, hit);
    if (exp_hit) begin
      check_bit("ext_ren on a hit", 1'b0, ext_log.size() != 0);
    end else begin
      check_bit("single ext_ren on a miss", 1'b1, ext_log.size() == 1);
      check_addr("ext_addr", a, ext_log[0]);
    end
  endtask

  task automatic test_data_rw();
    data_write(32'h0000_0800, 32'h1122_3344, 4'b1111);
    data_write(32'h0000_0804, 32'haabb_ccdd, 4'b0101);
    data_write(32'h0000_0808, 32'h5566_7788, 4'b1000);
    // partial write over a full one
    data_write(32'h0000_0800, 32'hffee_0000, 4'b0010);
    data_read_check(32'h0000_0800);
    data_read_check(32'h0000_0804);
    data_read_check(32'h0000_0808);
    data_read_check(32'h0000_080c);
  endtask

  task automatic test_miss_hit();
    fetch_check(32'h0000_0040, 1'b0);
    fetch_check(32'h0000_0040, 1'b1);
  endtask

  // two addresses on the same line evict each other
  task automatic test_conflict();
    mem_pkg::addr_t a;
    mem_pkg::addr_t b;
    a = 32'h0000_0100;
    b = a + ICACHE_LINES * 4;
    for (int k = 0; k < 3; k++) begin
      fetch_check(a, 1'b0);
      fetch_check(b, 1'b0);
    end
  endtask

  // data wins when both sides ask in the same cycle
  task automatic test_arbitration();
    mem_pkg::addr_t ia;
    mem_pkg::addr_t da;
    mem_pkg::word_t ird;
    mem_pkg::word_t drd;
    logic           hit;
    ia = 32'h0000_0200;
    da = 32'h0000_0840;
    ext_log.delete();
    fork
      fetch(ia, ird, hit);
      data_access(1'b0, da, '0, mem_pkg::BYTE_EN_ALL, drd);
    join
    check_bit("two ext accesses", 1'b1, ext_log.size() == 2);
    check_addr("first ext_addr", da, ext_log[0]);
    check_addr("second ext_addr", ia, ext_log[1]);
    check_word("i_rdata", pattern(ia), ird);
    check_word("d_rdata", shadow[da[2 +: IDX_W]], drd);
  endtask

  // fetches in 0x000-0x0fc, data in 0xa00-0xa3c
  task automatic test_random();
    mem_pkg::addr_t a;
    mem_pkg::word_t rd;
    logic           hit;
    logic [31:0]    r;
    for (int k = 0; k < 200; k++) begin
      r = $random(seed);
      if (!r[1]) begin
        a = {r[7:2], 2'b00};
        fetch(a, rd, hit);
        check_word("i_rdata", pattern(a), rd);
      end else if (r[0]) begin
        data_write(32'h0000_0a00 + {r[5:2], 2'b00}, $random(seed), r[11:8]);
      end else begin
        data_read_check(32'h0000_0a00 + {r[5:2], 2'b00});
      end
    end
  endtask

  task automatic test_halt();
    mem_pkg::addr_t da;
    mem_pkg::word_t rd;
    da = 32'h0000_0a04;
    fork
      data_access(1'b0, da, '0, mem_pkg::BYTE_EN_ALL, rd);
      begin
        @(posedge CLK);
        @(posedge CLK);
        halt_instr <= 1'b1;
        @(posedge CLK);
        halt_instr <= 1'b0;
        // held off by the outstanding read
        do begin
          @(negedge CLK);
          check_bit("halt", 1'b0, halt);
        end while (d_busy);
      end
    join
    check_word("d_rdata", shadow[da[2 +: IDX_W]], rd);
    @(negedge CLK);
    check_bit("halt", 1'b1, halt);
    // later requests never reach the external bus
    @(posedge CLK);
    d_ren  <= 1'b1;
    d_addr <= da;
    i_ren  <= 1'b1;
    i_addr <= 32'h0000_0300;
    repeat (20) begin
      @(negedge CLK);
      check_bit("ext_ren", 1'b0, ext_ren);
      check_bit("ext_wen", 1'b0, ext_wen);
      check_bit("d_busy", 1'b1, d_busy);
      check_bit("halt", 1'b1, halt);
    end
    @(posedge CLK);
    d_ren <= 1'b0;
    i_ren <= 1'b0;
  endtask

  initial begin
    nRST       = 1'b0;
    halt_instr = 1'b0;
    i_ren      = 1'b0;
    i_addr     = '0;
    d_ren      = 1'b0;
    d_wen      = 1'b0;
    d_addr     = '0;
    d_wdata    = '0;
    d_byte_en  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = pattern(i * 4);
    end
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    // idle state right after reset
    @(negedge CLK);
    check_bit("ext_ren", 1'b0, ext_ren);
    check_bit("ext_wen", 1'b0, ext_wen);
    check_bit("halt", 1'b0, halt);
    check_bit("i_busy", 1'b1, i_busy);
    check_bit("d_busy", 1'b1, d_busy);
    test_data_rw();
    test_miss_hit();
    test_conflict();
    test_arbitration();
    test_random();
    test_halt();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
